/* src/cpu_wb_pkg.sv */
package cpu_wb_pkg;

    // --------------------
    // Core sizes
    // --------------------
    localparam int ROB_DEPTH = 16;
    localparam int ROB_W     = 4;
    localparam int PHYS_REGS = 64;
    localparam int PHYS_W    = 6;
    localparam int EPOCH_W   = 2;

    // --------------------
    // Per-unit results
    // --------------------

    // ALU completion with an optional register result
    typedef struct packed {
        logic [ROB_W-1:0]   rob_idx;
        logic [EPOCH_W-1:0] epoch;
        logic [PHYS_W-1:0]  prd_new;
        logic [31:0]        data;
        logic               uses_rd;
    } alu_res_t;

    // Branch resolution
    // Data carries the link value for JAL/JALR when uses_rd is set
    typedef struct packed {
        logic [ROB_W-1:0]   rob_idx;
        logic [EPOCH_W-1:0] epoch;
        logic [PHYS_W-1:0]  prd_new;
        logic [31:0]        data;
        logic               uses_rd;
        logic [31:0]        pc;
        logic               act_taken;
        logic               mispredict;
        logic [31:0]        redirect_pc;
    } bru_res_t;

    // Load/store completion
    typedef struct packed {
        logic [ROB_W-1:0]   rob_idx;
        logic [EPOCH_W-1:0] epoch;
        logic [PHYS_W-1:0]  prd_new;
        logic [31:0]        data;
        logic               uses_rd;
        logic               is_load;
        logic               is_store;
        logic               mem_exc;
        logic [31:0]        mem_addr;
    } lsu_res_t;

    // --------------------
    // Common data bus packet
    // --------------------
    // Every transfer is a completion
    // Mispredict also requests the redirect
    typedef struct packed {
        logic [ROB_W-1:0]   rob_idx;
        logic [EPOCH_W-1:0] epoch;
        logic               uses_rd;
        logic [PHYS_W-1:0]  prd_new;
        logic [31:0]        data;
        logic               is_branch;
        logic               act_taken;
        logic               mispredict;
        logic [31:0]        redirect_pc;
        logic [31:0]        pc;
        logic               is_load;
        logic               is_store;
        logic               mem_exc;
        logic [31:0]        mem_addr;
    } fu_wb_t;

endpackage

/* src/fu_wb_buf.sv */
`timescale 1ns/1ps

module fu_wb_buf #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     arst_n,

    // From the functional unit
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,

    // Towards the bus arbiter
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    // Open when empty or when the held result drains this edge
    assign in_ready = !out_valid || out_ready;

    // Occupancy flag
    // Refilled or emptied only when the slot is free to change
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    // Capture the result on each accepted handshake
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= in_data;
        end
    end

endmodule

/* src/cdb_arbiter.sv */
`timescale 1ns/1ps

module cdb_arbiter (
    // ALU buffer
    input  logic                 alu_valid,
    output logic                 alu_ready,
    input  cpu_wb_pkg::alu_res_t alu_data,

    // Branch unit buffer
    input  logic                 bru_valid,
    output logic                 bru_ready,
    input  cpu_wb_pkg::bru_res_t bru_data,

    // Load/store buffer
    input  logic                 lsu_valid,
    output logic                 lsu_ready,
    input  cpu_wb_pkg::lsu_res_t lsu_data,

    // Common data bus
    input  logic                 cdb_ready,
    output logic                 cdb_valid,
    output cpu_wb_pkg::fu_wb_t   cdb_pkt,
    output logic                 cdb_fire
);

    // --------------------
    // Unit select
    // --------------------
    typedef enum logic [1:0] {
        SEL_NONE = 2'd0,
        SEL_BRU  = 2'd1,
        SEL_LSU  = 2'd2,
        SEL_ALU  = 2'd3
    } sel_e;

    sel_e sel;

    // Branch unit first since a redirect saves the most wasted work
    always_comb begin
        if (bru_valid) begin
            sel = SEL_BRU;
        end else if (lsu_valid) begin
            sel = SEL_LSU;
        end else if (alu_valid) begin
            sel = SEL_ALU;
        end else begin
            sel = SEL_NONE;
        end
    end

    assign cdb_valid = (sel != SEL_NONE);
    // Single transfer event shared by the done table and the register file
    assign cdb_fire  = cdb_valid && cdb_ready;

    // --------------------
    // Packet build
    // --------------------
    // Fields the selected unit lacks stay at zero
    always_comb begin
        cdb_pkt = '0;
        case (sel)
            SEL_BRU: begin
                cdb_pkt.rob_idx     = bru_data.rob_idx;
                cdb_pkt.epoch       = bru_data.epoch;
                cdb_pkt.uses_rd     = bru_data.uses_rd;
                cdb_pkt.prd_new     = bru_data.prd_new;
                cdb_pkt.data        = bru_data.data;
                cdb_pkt.is_branch   = 1'b1;
                cdb_pkt.act_taken   = bru_data.act_taken;
                cdb_pkt.mispredict  = bru_data.mispredict;
                cdb_pkt.redirect_pc = bru_data.redirect_pc;
                cdb_pkt.pc          = bru_data.pc;
            end
            SEL_LSU: begin
                cdb_pkt.rob_idx  = lsu_data.rob_idx;
                cdb_pkt.epoch    = lsu_data.epoch;
                cdb_pkt.uses_rd  = lsu_data.uses_rd;
                cdb_pkt.prd_new  = lsu_data.prd_new;
                cdb_pkt.data     = lsu_data.data;
                cdb_pkt.is_load  = lsu_data.is_load;
                cdb_pkt.is_store = lsu_data.is_store;
                cdb_pkt.mem_exc  = lsu_data.mem_exc;
                cdb_pkt.mem_addr = lsu_data.mem_addr;
            end
            SEL_ALU: begin
                cdb_pkt.rob_idx = alu_data.rob_idx;
                cdb_pkt.epoch   = alu_data.epoch;
                cdb_pkt.uses_rd = alu_data.uses_rd;
                cdb_pkt.prd_new = alu_data.prd_new;
                cdb_pkt.data    = alu_data.data;
            end
            default: begin
                cdb_pkt = '0;
            end
        endcase
    end

    // Only the winner sees ready, and only while the bus accepts
    assign bru_ready = (sel == SEL_BRU) && cdb_ready;
    assign lsu_ready = (sel == SEL_LSU) && cdb_ready;
    assign alu_ready = (sel == SEL_ALU) && cdb_ready;

endmodule

/* src/rob_done_table.sv */
`timescale 1ns/1ps

module rob_done_table (
    input  logic                           clk,
    input  logic                           arst_n,

    // Bus transfer
    input  logic                           cdb_fire,
    input  cpu_wb_pkg::fu_wb_t             cdb_pkt,

    // Epoch and flush from the front end
    input  logic [cpu_wb_pkg::EPOCH_W-1:0] cur_epoch,
    input  logic                           flush,

    // Status read port for retirement
    input  logic [cpu_wb_pkg::ROB_W-1:0]   rd_idx,
    output logic                           rd_done,
    output logic                           rd_exc,
    output logic                           rd_mispredict,

    // Fetch redirect
    output logic                           redirect_valid,
    output logic [31:0]                    redirect_pc
);

    import cpu_wb_pkg::*;

    logic [ROB_DEPTH-1:0] done_q;
    logic [ROB_DEPTH-1:0] exc_q;
    logic [ROB_DEPTH-1:0] mispr_q;
    logic                 accept;
    logic                 take_redirect;

    // --------------------
    // Epoch filter
    // --------------------
    // Old epoch means a wrong-path result so the entry is left alone
    assign accept        = cdb_fire && (cdb_pkt.epoch == cur_epoch) && !flush;
    assign take_redirect = accept && cdb_pkt.is_branch && cdb_pkt.mispredict;

    // Status bits
    // Flush wins over a same-cycle transfer
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            done_q  <= '0;
            exc_q   <= '0;
            mispr_q <= '0;
        end else if (flush) begin
            done_q  <= '0;
            exc_q   <= '0;
            mispr_q <= '0;
        end else if (accept) begin
            done_q[cdb_pkt.rob_idx]  <= 1'b1;
            exc_q[cdb_pkt.rob_idx]   <= cdb_pkt.mem_exc;
            mispr_q[cdb_pkt.rob_idx] <= cdb_pkt.mispredict;
        end
    end

    // --------------------
    // Redirect pulse
    // --------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            redirect_valid <= 1'b0;
        end else begin
            redirect_valid <= take_redirect;
        end
    end

    // Target is held until the next mispredict
    always_ff @(posedge clk) begin
        if (take_redirect) begin
            redirect_pc <= cdb_pkt.redirect_pc;
        end
    end

    assign rd_done       = done_q[rd_idx];
    assign rd_exc        = exc_q[rd_idx];
    assign rd_mispredict = mispr_q[rd_idx];

endmodule

/* src/prf_wb.sv */
`timescale 1ns/1ps

module prf_wb (
    input  logic                          clk,
    input  logic                          arst_n,

    // Bus transfer
    input  logic                          cdb_fire,
    input  cpu_wb_pkg::fu_wb_t            cdb_pkt,

    // Ready clear from rename on allocation
    input  logic                          clear_ready,
    input  logic [cpu_wb_pkg::PHYS_W-1:0] clear_idx,

    // Operand read port
    input  logic [cpu_wb_pkg::PHYS_W-1:0] rd_idx,
    output logic [31:0]                   rd_data,
    output logic                          rd_ready
);

    import cpu_wb_pkg::*;

    logic [31:0]          regs_q [PHYS_REGS];
    logic [PHYS_REGS-1:0] ready_q;
    logic                 wr_en;

    // Stale epochs still write since no live reader uses that register
    assign wr_en = cdb_fire && cdb_pkt.uses_rd;

    // --------------------
    // Register array
    // --------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            regs_q <= '{default: 32'h0};
        end else if (wr_en) begin
            regs_q[cdb_pkt.prd_new] <= cdb_pkt.data;
        end
    end

    // Ready bits
    // Write comes last so it wins over a clear of the same index
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ready_q <= '1;
        end else begin
            if (clear_ready) begin
                ready_q[clear_idx] <= 1'b0;
            end
            if (wr_en) begin
                ready_q[cdb_pkt.prd_new] <= 1'b1;
            end
        end
    end

    assign rd_data  = regs_q[rd_idx];
    assign rd_ready = ready_q[rd_idx];

endmodule

/* src/wb_top.sv */
`timescale 1ns/1ps

module wb_top (
    input  logic                           clk,
    input  logic                           arst_n,

    // Functional unit results
    input  logic                           alu_in_valid,
    output logic                           alu_in_ready,
    input  cpu_wb_pkg::alu_res_t           alu_in,
    input  logic                           bru_in_valid,
    output logic                           bru_in_ready,
    input  cpu_wb_pkg::bru_res_t           bru_in,
    input  logic                           lsu_in_valid,
    output logic                           lsu_in_ready,
    input  cpu_wb_pkg::lsu_res_t           lsu_in,

    // Common data bus with external back-pressure
    input  logic                           cdb_ready,
    output logic                           cdb_valid,
    output cpu_wb_pkg::fu_wb_t             cdb_pkt,

    // Reorder buffer side
    input  logic [cpu_wb_pkg::EPOCH_W-1:0] cur_epoch,
    input  logic                           flush,
    input  logic [cpu_wb_pkg::ROB_W-1:0]   rob_rd_idx,
    output logic                           rob_rd_done,
    output logic                           rob_rd_exc,
    output logic                           rob_rd_mispredict,
    output logic                           redirect_valid,
    output logic [31:0]                    redirect_pc,

    // Register file side
    input  logic                           clear_ready,
    input  logic [cpu_wb_pkg::PHYS_W-1:0]  clear_idx,
    input  logic [cpu_wb_pkg::PHYS_W-1:0]  prf_rd_idx,
    output logic [31:0]                    prf_rd_data,
    output logic                           prf_rd_ready
);

    import cpu_wb_pkg::*;

    // Buffer to arbiter links
    logic     alu_buf_valid, alu_buf_ready;
    logic     bru_buf_valid, bru_buf_ready;
    logic     lsu_buf_valid, lsu_buf_ready;
    alu_res_t alu_buf_data;
    bru_res_t bru_buf_data;
    lsu_res_t lsu_buf_data;
    logic     cdb_fire;

    // --------------------
    // Writeback buffers
    // --------------------
    fu_wb_buf #(.payload_t(alu_res_t)) u_alu_buf (
        .clk(clk), .arst_n(arst_n),
        .in_valid(alu_in_valid), .in_ready(alu_in_ready), .in_data(alu_in),
        .out_valid(alu_buf_valid), .out_ready(alu_buf_ready), .out_data(alu_buf_data)
    );

    fu_wb_buf #(.payload_t(bru_res_t)) u_bru_buf (
        .clk(clk), .arst_n(arst_n),
        .in_valid(bru_in_valid), .in_ready(bru_in_ready), .in_data(bru_in),
        .out_valid(bru_buf_valid), .out_ready(bru_buf_ready), .out_data(bru_buf_data)
    );

    fu_wb_buf #(.payload_t(lsu_res_t)) u_lsu_buf (
        .clk(clk), .arst_n(arst_n),
        .in_valid(lsu_in_valid), .in_ready(lsu_in_ready), .in_data(lsu_in),
        .out_valid(lsu_buf_valid), .out_ready(lsu_buf_ready), .out_data(lsu_buf_data)
    );

    // --------------------
    // Bus and consumers
    // --------------------
    cdb_arbiter u_arb (
        .alu_valid(alu_buf_valid), .alu_ready(alu_buf_ready), .alu_data(alu_buf_data),
        .bru_valid(bru_buf_valid), .bru_ready(bru_buf_ready), .bru_data(bru_buf_data),
        .lsu_valid(lsu_buf_valid), .lsu_ready(lsu_buf_ready), .lsu_data(lsu_buf_data),
        .cdb_ready(cdb_ready), .cdb_valid(cdb_valid), .cdb_pkt(cdb_pkt),
        .cdb_fire(cdb_fire)
    );

    rob_done_table u_rob (
        .clk(clk), .arst_n(arst_n),
        .cdb_fire(cdb_fire), .cdb_pkt(cdb_pkt),
        .cur_epoch(cur_epoch), .flush(flush),
        .rd_idx(rob_rd_idx), .rd_done(rob_rd_done), .rd_exc(rob_rd_exc),
        .rd_mispredict(rob_rd_mispredict),
        .redirect_valid(redirect_valid), .redirect_pc(redirect_pc)
    );

    prf_wb u_prf (
        .clk(clk), .arst_n(arst_n),
        .cdb_fire(cdb_fire), .cdb_pkt(cdb_pkt),
        .clear_ready(clear_ready), .clear_idx(clear_idx),
        .rd_idx(prf_rd_idx), .rd_data(prf_rd_data), .rd_ready(prf_rd_ready)
    );

endmodule

/* tb/wb_top_checker.sv */
`timescale 1ns/1ps

module wb_top_checker (
    input logic                 clk,
    input logic                 arst_n,
    // Buffer side of the arbiter
    input logic                 alu_valid,
    input logic                 alu_ready,
    input cpu_wb_pkg::alu_res_t alu_data,
    input logic                 bru_valid,
    input logic                 bru_ready,
    input cpu_wb_pkg::bru_res_t bru_data,
    input logic                 lsu_valid,
    input logic                 lsu_ready,
    input cpu_wb_pkg::lsu_res_t lsu_data,
    // Bus and done table
    input logic                 cdb_ready,
    input logic                 cdb_valid,
    input logic                 cdb_fire,
    input cpu_wb_pkg::fu_wb_t   cdb_pkt,
    input logic                 redirect_valid
);

    import cpu_wb_pkg::*;

    int unsigned fail_cnt = 0;

    // --------------------
    // Arbiter
    // --------------------
    // At most one unit granted per cycle
    a_ready_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0({alu_ready, bru_ready, lsu_ready}))
        else begin fail_cnt++; $error("more than one unit ready"); end

    // Branch unit first, then load/store, then ALU
    a_bru_first: assert property (@(posedge clk) disable iff (!arst_n)
        bru_valid |-> !lsu_ready && !alu_ready)
        else begin fail_cnt++; $error("lower unit granted over branch unit"); end
    a_lsu_before_alu: assert property (@(posedge clk) disable iff (!arst_n)
        lsu_valid |-> !alu_ready)
        else begin fail_cnt++; $error("ALU granted over load/store unit"); end

    // Stalled bus stays valid, waiting units hold their results
    a_bus_hold: assert property (@(posedge clk) disable iff (!arst_n)
        cdb_valid && !cdb_ready |=> cdb_valid)
        else begin fail_cnt++; $error("bus valid dropped under back-pressure"); end
    a_bru_hold: assert property (@(posedge clk) disable iff (!arst_n)
        bru_valid && !bru_ready |=> bru_valid && $stable(bru_data))
        else begin fail_cnt++; $error("branch result changed while waiting"); end
    a_lsu_hold: assert property (@(posedge clk) disable iff (!arst_n)
        lsu_valid && !lsu_ready |=> lsu_valid && $stable(lsu_data))
        else begin fail_cnt++; $error("load/store result changed while waiting"); end
    a_alu_hold: assert property (@(posedge clk) disable iff (!arst_n)
        alu_valid && !alu_ready |=> alu_valid && $stable(alu_data))
        else begin fail_cnt++; $error("ALU result changed while waiting"); end

    // --------------------
    // Done table
    // --------------------
    // Each pulse cycle traces back to its own mispredicted transfer
    a_redirect_single: assert property (@(posedge clk) disable iff (!arst_n)
        redirect_valid |-> $past(cdb_fire && cdb_pkt.is_branch && cdb_pkt.mispredict))
        else begin fail_cnt++; $error("redirect pulse without a matching transfer"); end

endmodule

bind wb_top wb_top_checker u_chk (
    .clk(clk), .arst_n(arst_n),
    .alu_valid(alu_buf_valid), .alu_ready(alu_buf_ready), .alu_data(alu_buf_data),
    .bru_valid(bru_buf_valid), .bru_ready(bru_buf_ready), .bru_data(bru_buf_data),
    .lsu_valid(lsu_buf_valid), .lsu_ready(lsu_buf_ready), .lsu_data(lsu_buf_data),
    .cdb_ready(cdb_ready), .cdb_valid(cdb_valid), .cdb_fire(cdb_fire),
    .cdb_pkt(cdb_pkt), .redirect_valid(redirect_valid)
);

/* tb/tb_wb_top.sv */
`timescale 1ns/1ps

module tb_wb_top;

    import cpu_wb_pkg::*;

    localparam int TIMEOUT_CYCLES = 200;

    logic clk, arst_n;
    logic alu_in_valid, alu_in_ready, bru_in_valid, bru_in_ready, lsu_in_valid, lsu_in_ready;
    alu_res_t alu_in;
    bru_res_t bru_in;
    lsu_res_t lsu_in;
    logic cdb_ready, cdb_valid, flush, clear_ready;
    fu_wb_t cdb_pkt;
    logic [EPOCH_W-1:0] cur_epoch;
    logic [ROB_W-1:0] rob_rd_idx;
    logic rob_rd_done, rob_rd_exc, rob_rd_mispredict, redirect_valid, prf_rd_ready;
    logic [31:0] redirect_pc, prf_rd_data;
    logic [PHYS_W-1:0] clear_idx, prf_rd_idx;

    // Scoreboard
    logic [ROB_DEPTH-1:0] exp_done, exp_exc, exp_mis;
    logic [PHYS_REGS-1:0] exp_rdy;
    logic [31:0] exp_reg [PHYS_REGS];
    logic [31:0] exp_redir_pc, redir_pc_seen, bp_rnd;
    logic [ROB_W-1:0] alu_q[$], bru_q[$], lsu_q[$], fire_log[$];
    logic [ROB_DEPTH-1:0] done_prev;
    logic [PHYS_W-1:0] stall_prd;
    logic [31:0] stall_reg;
    logic quiet_prev;
    integer seed = 1797;
    int errors = 0;
    int redir_cnt = 0;
    int want, c0;

    wb_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // --------------------
    // Check helpers
    // --------------------
    function automatic void expect_eq(input string name, input int idx,
                                      input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("Error: %s[%0h] got %0h exp %0h", name, idx, got, exp);
        end
    endfunction

    task automatic stop_on_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        $display("TB FAILED");
        $finish;
    endtask

    // Expected state follows the writeback rules at hand-in time
    function automatic void record_result(input logic [ROB_W-1:0] rob, input logic [PHYS_W-1:0] prd,
                                          input logic [EPOCH_W-1:0] ep, input logic [31:0] data,
                                          input logic uses_rd, input logic exc, input logic mis);
        if (uses_rd) begin
            exp_reg[prd] = data;
            exp_rdy[prd] = 1'b1;
        end
        if (ep == cur_epoch) begin
            exp_done[rob] = 1'b1;
            exp_exc[rob]  = exc;
            exp_mis[rob]  = mis;
        end
    endfunction

    // Caller sits on a falling edge
    task automatic check_entry(input int r, input int p);
        rob_rd_idx = 4'(r);
        prf_rd_idx = 6'(p);
        #1;
        expect_eq("prf_rd_data", p, prf_rd_data, exp_reg[p]);
        expect_eq("prf_rd_ready", p, 32'(prf_rd_ready), 32'(exp_rdy[p]));
        expect_eq("rob_rd_done", r, 32'(rob_rd_done), 32'(exp_done[r]));
        expect_eq("rob_rd_exc", r, 32'(rob_rd_exc), 32'(exp_exc[r]));
        expect_eq("rob_rd_mispredict", r, 32'(rob_rd_mispredict), 32'(exp_mis[r]));
    endtask

    task automatic check_all_entries();
        for (int j = 0; j < PHYS_REGS; j++) begin
            @(negedge clk);
            check_entry(j % ROB_DEPTH, j);
        end
    endtask

    task automatic wait_bus_idle();
        int t;
        t = 0;
        @(negedge clk);
        #1;
        while (cdb_valid) begin
            @(negedge clk);
            #1;
            t++;
            if (t > TIMEOUT_CYCLES) stop_on_timeout("the bus to drain");
        end
        repeat (2) @(negedge clk);
        #5;
    endtask

    // --------------------
    // Unit drivers
    // --------------------
    task automatic send_alu(input logic [ROB_W-1:0] rob, input logic [PHYS_W-1:0] prd,
                            input logic [EPOCH_W-1:0] ep);
        alu_res_t r;
        int t;
        r = '0;
        r.rob_idx = rob;
        r.epoch = ep;
        r.prd_new = prd;
        r.data = $random(seed);
        r.uses_rd = 1'b1;
        @(negedge clk);
        alu_in = r;
        alu_in_valid = 1'b1;
        t = 0;
        #1;
        while (!alu_in_ready) begin
            @(negedge clk);
            #1;
            t++;
            if (t > TIMEOUT_CYCLES) stop_on_timeout("alu_in_ready");
        end
        alu_q.push_back(rob);
        record_result(rob, prd, ep, r.data, 1'b1, 1'b0, 1'b0);
        @(negedge clk);
        alu_in_valid = 1'b0;
    endtask

    task automatic send_bru(input logic [ROB_W-1:0] rob, input logic [PHYS_W-1:0] prd,
                            input logic [EPOCH_W-1:0] ep, input logic uses_rd, input logic mis);
        bru_res_t r;
        int t;
        r = '0;
        r.rob_idx = rob;
        r.epoch = ep;
        r.prd_new = prd;
        r.pc = $random(seed);
        // Link value of a JAL
        r.data = r.pc + 32'd4;
        r.uses_rd = uses_rd;
        r.act_taken = 1'b1;
        r.mispredict = mis;
        r.redirect_pc = $random(seed);
        @(negedge clk);
        bru_in = r;
        bru_in_valid = 1'b1;
        t = 0;
        #1;
        while (!bru_in_ready) begin
            @(negedge clk);
            #1;
            t++;
            if (t > TIMEOUT_CYCLES) stop_on_timeout("bru_in_ready");
        end
        bru_q.push_back(rob);
        record_result(rob, prd, ep, r.data, uses_rd, 1'b0, mis);
        if (mis && ep == cur_epoch) exp_redir_pc = r.redirect_pc;
        @(negedge clk);
        bru_in_valid = 1'b0;
    endtask

    task automatic send_lsu(input logic [ROB_W-1:0] rob, input logic [PHYS_W-1:0] prd,
                            input logic [EPOCH_W-1:0] ep, input logic exc);
        lsu_res_t r;
        int t;
        r = '0;
        r.rob_idx = rob;
        r.epoch = ep;
        r.prd_new = prd;
        r.data = $random(seed);
        r.uses_rd = 1'b1;
        r.is_load = 1'b1;
        r.mem_exc = exc;
        r.mem_addr = $random(seed);
        @(negedge clk);
        lsu_in = r;
        lsu_in_valid = 1'b1;
        t = 0;
        #1;
        while (!lsu_in_ready) begin
            @(negedge clk);
            #1;
            t++;
            if (t > TIMEOUT_CYCLES) stop_on_timeout("lsu_in_ready");
        end
        lsu_q.push_back(rob);
        record_result(rob, prd, ep, r.data, 1'b1, exc, 1'b0);
        @(negedge clk);
        lsu_in_valid = 1'b0;
    endtask

    // --------------------
    // Bus monitor
    // --------------------
    // Samples after the falling-edge drive has settled
    initial begin
        quiet_prev = 1'b0;
        forever begin
            @(negedge clk);
            #2;
            if (arst_n && cdb_valid && cdb_ready) begin
                // Per-unit order must match hand-in order
                want = -1;
                if (cdb_pkt.is_branch && bru_q.size() > 0) want = 32'(bru_q.pop_front());
                else if (cdb_pkt.is_load && lsu_q.size() > 0) want = 32'(lsu_q.pop_front());
                else if (!cdb_pkt.is_branch && !cdb_pkt.is_load && alu_q.size() > 0)
                    want = 32'(alu_q.pop_front());
                expect_eq("cdb_pkt.rob_idx", fire_log.size(), 32'(cdb_pkt.rob_idx), want);
                fire_log.push_back(cdb_pkt.rob_idx);
            end
            if (redirect_valid) begin
                redir_cnt++;
                redir_pc_seen = redirect_pc;
            end
            // Stalled bus and no flush leaves the done bits and the pending register alone
            if (quiet_prev) begin
                expect_eq("done_q", 0, 32'(DUT.u_rob.done_q), 32'(done_prev));
                expect_eq("regs_q", stall_prd, DUT.u_prf.regs_q[stall_prd], stall_reg);
            end
            quiet_prev = !cdb_ready && !flush;
            done_prev = DUT.u_rob.done_q;
            stall_prd = cdb_pkt.prd_new;
            stall_reg = DUT.u_prf.regs_q[cdb_pkt.prd_new];
        end
    end

    // --------------------
    // Stimulus
    // --------------------
    initial begin
        arst_n = 1'b0;
        {alu_in_valid, bru_in_valid, lsu_in_valid, flush, clear_ready} = '0;
        alu_in = '0;
        bru_in = '0;
        lsu_in = '0;
        cdb_ready = 1'b1;
        cur_epoch = '0;
        {rob_rd_idx, clear_idx, prf_rd_idx} = '0;
        {exp_done, exp_exc, exp_mis} = '0;
        exp_rdy = '1;
        exp_redir_pc = '0;
        redir_pc_seen = '0;
        for (int j = 0; j < PHYS_REGS; j++) exp_reg[j] = '0;
        repeat (2) @(negedge clk);
        arst_n = 1'b1;

        // Single results, done and written two edges after hand-in
        send_alu(4'd1, 6'd1, cur_epoch);
        @(negedge clk);
        check_entry(1, 1);
        send_bru(4'd2, 6'd2, cur_epoch, 1'b1, 1'b0);
        @(negedge clk);
        check_entry(2, 2);
        send_lsu(4'd3, 6'd3, cur_epoch, 1'b1);
        @(negedge clk);
        check_entry(3, 3);

        // Priority with all three units in the same cycle
        wait_bus_idle();
        fire_log.delete();
        fork
            send_alu(4'd3, 6'd33, cur_epoch);
            send_bru(4'd1, 6'd31, cur_epoch, 1'b1, 1'b0);
            send_lsu(4'd2, 6'd32, cur_epoch, 1'b0);
        join
        wait_bus_idle();
        expect_eq("cdb_fire count", 0, fire_log.size(), 3);
        for (int k = 0; k < 3; k++) expect_eq("fire order", k, 32'(fire_log[k]), k + 1);

        // Random back-pressure stretches
        fork
            for (int k = 0; k < 4; k++) send_bru(4'(k), 6'(16 + k), cur_epoch, 1'b1, 1'b0);
            for (int k = 0; k < 4; k++) send_lsu(4'(4 + k), 6'(20 + k), cur_epoch, 1'(k));
            for (int k = 0; k < 4; k++) send_alu(4'(8 + k), 6'(24 + k), cur_epoch);
            begin
                repeat (12) begin
                    bp_rnd = $random(seed);
                    @(negedge clk);
                    cdb_ready = bp_rnd[0];
                    repeat (bp_rnd[3:1]) @(negedge clk);
                end
                @(negedge clk);
                cdb_ready = 1'b1;
            end
        join
        wait_bus_idle();
        check_all_entries();

        // Flush and a new epoch, then a stale and a current result
        @(negedge clk);
        flush = 1'b1;
        cur_epoch = 2'd1;
        @(negedge clk);
        flush = 1'b0;
        {exp_done, exp_exc, exp_mis} = '0;
        send_alu(4'd5, 6'd40, 2'd0);
        send_lsu(4'd6, 6'd41, 2'd1, 1'b1);
        wait_bus_idle();
        check_entry(5, 40);
        check_entry(6, 41);
        // Flush lands on the same edge as the bus transfer
        send_alu(4'd7, 6'd42, cur_epoch);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        {exp_done, exp_exc, exp_mis} = '0;
        check_entry(7, 42);

        // Redirect only for a current mispredicted branch
        c0 = redir_cnt;
        send_bru(4'd8, 6'd43, 2'd1, 1'b1, 1'b1);
        wait_bus_idle();
        expect_eq("redirect_valid pulses", 8, redir_cnt - c0, 1);
        expect_eq("redirect_pc", 8, redir_pc_seen, exp_redir_pc);
        send_bru(4'd9, 6'd44, 2'd1, 1'b1, 1'b0);
        send_bru(4'd10, 6'd45, 2'd0, 1'b0, 1'b1);
        wait_bus_idle();
        expect_eq("redirect_valid pulses", 10, redir_cnt - c0, 1);

        // Ready bits, clear then rewrite, then clear and write together
        @(negedge clk);
        clear_ready = 1'b1;
        clear_idx = 6'd50;
        @(negedge clk);
        clear_ready = 1'b0;
        exp_rdy[50] = 1'b0;
        check_entry(0, 50);
        send_alu(4'd11, 6'd50, cur_epoch);
        send_alu(4'd12, 6'd51, cur_epoch);
        clear_ready = 1'b1;
        clear_idx = 6'd51;
        @(negedge clk);
        clear_ready = 1'b0;
        wait_bus_idle();
        check_all_entries();
        expect_eq("pending results", 0, alu_q.size() + bru_q.size() + lsu_q.size(), 0);

        $display("Checks done: %0d value errors, %0d assertion failures",
                 errors, DUT.u_chk.fail_cnt);
        if (errors == 0 && DUT.u_chk.fail_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* wb_top.f */
src/cpu_wb_pkg.sv
src/fu_wb_buf.sv
src/cdb_arbiter.sv
src/rob_done_table.sv
src/prf_wb.sv
src/wb_top.sv
tb/wb_top_checker.sv
tb/tb_wb_top.sv

/* Makefile */
# Verilator build and run of the writeback stage testbench

SIM      ?= verilator
TOP      ?= tb_wb_top
VFLAGS   ?= -j 0
BUILD    ?= obj_dir
LOG      ?= sim.log
RUNFLAGS ?= +verilator+error+limit+1000

FILELIST := wb_top.f
SRCS     := $(shell grep -v '^+' $(FILELIST))
BIN      := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) --binary --timing --assert --top-module $(TOP) -Mdir $(BUILD) $(VFLAGS) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(RUNFLAGS) 2>&1 | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "TB PASSED" $(LOG) || (echo "No pass message in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
